// File: common/standby_pkg.sv
// Shared widths, byte count and data types of the standby queue bridge

package standby_pkg;

  // Byte-wide transfer queues of the target
  localparam int unsigned TTI_BYTE_W = 8;

  // Word width of the I2C engine
  localparam int unsigned I2C_WORD_W = 32;

  // Bytes carried by one I2C engine word
  localparam int unsigned BYTES_PER_WORD = I2C_WORD_W / TTI_BYTE_W;

  // Lane index width within one word
  localparam int unsigned BYTE_IDX_W = $clog2(BYTES_PER_WORD);

  // One queue byte
  typedef logic [TTI_BYTE_W-1:0] tti_byte_t;

  // One I2C engine word with lane 0 in the low byte
  typedef logic [I2C_WORD_W-1:0] i2c_word_t;

  // Selects one byte lane of a word
  typedef logic [BYTE_IDX_W-1:0] byte_idx_t;

  // Last lane index shared by both converters
  localparam byte_idx_t LAST_LANE = byte_idx_t'(BYTES_PER_WORD - 1);

  // Lane count and word width must agree
  localparam bit WIDTHS_MATCH = (BYTES_PER_WORD * TTI_BYTE_W) == I2C_WORD_W;

endpackage

// File: files.f
common/standby_pkg.sv
width_conv/rx_word_unpacker.sv
width_conv/tx_byte_packer.sv
verilog/standby_queue_bridge.sv
verif/standby_queue_bridge_properties.sv
verif/tb_standby_queue_bridge.sv

// File: run.sh
#!/bin/sh
# Builds and runs the standby queue bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_standby_queue_bridge \
  -f files.f \
  --Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

"./$BUILD_DIR/sim_tb"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

// File: verif/standby_queue_bridge_properties.sv
// Handshake stability, inactive path and error flag assertions for the queue bridge
`timescale 1ns/1ps

module standby_queue_bridge_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   i3c_active_en_i,
  input logic                   i3c_standby_en_i,
  input logic                   rx_queue_wvalid_o,
  input standby_pkg::tti_byte_t rx_queue_wdata_o,
  input logic                   rx_queue_wready_i,
  input logic                   i2c_tx_rvalid_o,
  input standby_pkg::i2c_word_t i2c_tx_rdata_o,
  input logic                   i2c_tx_rready_i,
  input logic                   i2c_rx_wready_o,
  input logic                   i3c_rx_wready_o,
  input logic                   i3c_tx_rvalid_o,
  input logic                   parity_err_i,
  input logic                   get_status_done_i,
  input logic                   err_o
);

  logic i3c_mode;
  assign i3c_mode = i3c_active_en_i | i3c_standby_en_i;

  // Byte towards the RX queue held while stalled
  rx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_o && !rx_queue_wready_i |=> rx_queue_wvalid_o && $stable(rx_queue_wdata_o))
    else $error("RX queue byte dropped or changed under back-pressure");

  tx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i2c_tx_rvalid_o && !i2c_tx_rready_i |=> i2c_tx_rvalid_o && $stable(i2c_tx_rdata_o))
    else $error("I2C TX word dropped or changed under back-pressure");

  // Inactive engine sees no handshake
  i2c_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i3c_mode |-> !i2c_rx_wready_o && !i2c_tx_rvalid_o)
    else $error("I2C handshake active in I3C mode");

  i3c_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !i3c_mode |-> !i3c_rx_wready_o && !i3c_tx_rvalid_o)
    else $error("I3C handshake active in I2C mode");

  err_set_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    parity_err_i && !get_status_done_i |=> err_o)
    else $error("Error flag not set after parity error");

  // Status read clears even against a parity error in the same cycle
  err_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    get_status_done_i |=> !err_o)
    else $error("Error flag not cleared after status read");

  err_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !parity_err_i && !get_status_done_i |=> $stable(err_o))
    else $error("Error flag changed without a cause");

endmodule

bind standby_queue_bridge standby_queue_bridge_properties u_props (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .i3c_active_en_i   (i3c_active_en_i),
  .i3c_standby_en_i  (i3c_standby_en_i),
  .rx_queue_wvalid_o (rx_queue_wvalid_o),
  .rx_queue_wdata_o  (rx_queue_wdata_o),
  .rx_queue_wready_i (rx_queue_wready_i),
  .i2c_tx_rvalid_o   (i2c_tx_rvalid_o),
  .i2c_tx_rdata_o    (i2c_tx_rdata_o),
  .i2c_tx_rready_i   (i2c_tx_rready_i),
  .i2c_rx_wready_o   (i2c_rx_wready_o),
  .i3c_rx_wready_o   (i3c_rx_wready_o),
  .i3c_tx_rvalid_o   (i3c_tx_rvalid_o),
  .parity_err_i      (parity_err_i),
  .get_status_done_i (get_status_done_i),
  .err_o             (err_o)
);

// File: verif/tb_standby_queue_bridge.sv
// Testbench for the standby queue bridge with stimulus table, reference queues and watchdog
`timescale 1ns/1ps

module tb_standby_queue_bridge;

  localparam time CLK_PERIOD = 100ns;
  localparam time STIM_DELAY = 5ns;
  localparam int  NUM_ROWS   = 8;
  localparam int  NB         = standby_pkg::BYTES_PER_WORD;
  localparam int  BW         = standby_pkg::TTI_BYTE_W;

  typedef struct packed {
    logic [1:0]  en;         // {active, standby}
    logic [31:0] rx_word;    // lane 0 in the low byte
    logic [31:0] tx_bytes;   // lane 0 in the low byte
    logic        ibi_valid;
    logic        ibi_ready;
    logic        flush;
    logic [2:0]  i2c_ev;     // {start, rstart, stop}
    logic [2:0]  i3c_ev;
    logic [7:0]  i2c_addr;
    logic        i2c_addr_v;
    logic [7:0]  i3c_addr;
    logic        i3c_addr_v;
    logic        parity;
    logic        status;
    logic        exp_err;
  } row_t;

  logic clk_i, rst_ni, i3c_active_en_i, i3c_standby_en_i;
  logic i2c_rx_wvalid_i, i2c_rx_wready_o, i3c_rx_wvalid_i, i3c_rx_wready_o;
  logic rx_queue_wvalid_o, rx_queue_wready_i, tx_queue_rvalid_i, tx_queue_rready_o;
  logic i2c_tx_rvalid_o, i2c_tx_rready_i, i3c_tx_rvalid_o, i3c_tx_rready_i;
  logic i3c_tx_flush_i, tx_queue_flush_o;
  logic ibi_queue_rvalid_i, ibi_queue_rready_o, ibi_rvalid_o, i3c_ibi_rready_i;
  logic i2c_bus_start_i, i2c_bus_rstart_i, i2c_bus_stop_i;
  logic i3c_bus_start_i, i3c_bus_rstart_i, i3c_bus_stop_i;
  logic bus_start_o, bus_rstart_o, bus_stop_o;
  logic [7:0] i2c_bus_addr_i, i3c_bus_addr_i, bus_addr_o;
  logic i2c_bus_addr_valid_i, i3c_bus_addr_valid_i, bus_addr_valid_o;
  logic parity_err_i, get_status_done_i, err_o;
  standby_pkg::i2c_word_t i2c_rx_wdata_i, i2c_tx_rdata_o;
  standby_pkg::tti_byte_t i3c_rx_wdata_i, rx_queue_wdata_o, tx_queue_rdata_i, i3c_tx_rdata_o;

  row_t rows [NUM_ROWS];

  // Reference queues of bytes and words still owed by the DUT
  standby_pkg::tti_byte_t exp_rx[$];
  standby_pkg::tti_byte_t exp_i3c_tx[$];
  standby_pkg::i2c_word_t exp_i2c_tx[$];
  standby_pkg::i2c_word_t tx_word;
  int tx_lane = 0;

  logic i3c_mode;
  assign i3c_mode = i3c_active_en_i | i3c_standby_en_i;

  standby_queue_bridge uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      report_failure($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, name, got, exp));
  endtask

  // Transfers sampled at the falling edge while valid and ready are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (i2c_rx_wvalid_i && i2c_rx_wready_o) begin
        assert (exp_rx.size() == 0) else
          report_failure("Unpacker accepted a new word before its last byte transferred");
        for (int k = 0; k < NB; k++) begin
          exp_rx.push_back(i2c_rx_wdata_i[k*BW +: BW]);
        end
      end
      if (i3c_rx_wvalid_i && i3c_rx_wready_o) begin
        exp_rx.push_back(i3c_rx_wdata_i);
      end
      if (rx_queue_wvalid_o && rx_queue_wready_i) begin
        assert (exp_rx.size() != 0) else
          report_failure("RX queue received a byte that was never sent");
        check_value("rx_queue_wdata_o", rx_queue_wdata_o, exp_rx.pop_front());
      end
      if (tx_queue_rvalid_i && tx_queue_rready_o) begin
        if (i3c_mode) begin
          exp_i3c_tx.push_back(tx_queue_rdata_i);
        end else begin
          // First byte of a group lands in lane 0
          tx_word[tx_lane*BW +: BW] = tx_queue_rdata_i;
          tx_lane = tx_lane + 1;
          if (tx_lane == NB) begin
            exp_i2c_tx.push_back(tx_word);
            tx_lane = 0;
          end
        end
      end
      if (i3c_tx_rvalid_o && i3c_tx_rready_i) begin
        assert (exp_i3c_tx.size() != 0) else
          report_failure("I3C engine received a TX byte that was never sent");
        check_value("i3c_tx_rdata_o", i3c_tx_rdata_o, exp_i3c_tx.pop_front());
      end
      if (i2c_tx_rvalid_o && i2c_tx_rready_i) begin
        assert (exp_i2c_tx.size() != 0) else
          report_failure("I2C engine received a TX word before four bytes were sent");
        check_value("i2c_tx_rdata_o", i2c_tx_rdata_o, exp_i2c_tx.pop_front());
      end
    end
  end

  task automatic load_table();
    rows[0] = '{2'b00, 32'h4433_2211, 32'hd4c3_b2a1, 1'b1, 1'b1, 1'b1,
                3'b100, 3'b011, 8'ha0, 1'b1, 8'h5b, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[1] = '{2'b00, 32'h8877_6655, 32'h0f1e_2d3c, 1'b0, 1'b1, 1'b0,
                3'b010, 3'b101, 8'h42, 1'b0, 8'h7e, 1'b1, 1'b1, 1'b0, 1'b1};
    rows[2] = '{2'b10, 32'hccbb_aa99, 32'h0403_0201, 1'b1, 1'b1, 1'b1,
                3'b001, 3'b110, 8'h12, 1'b1, 8'hd3, 1'b1, 1'b0, 1'b0, 1'b1};
    rows[3] = '{2'b01, 32'h5a5a_a5a5, 32'hdead_beef, 1'b1, 1'b0, 1'b0,
                3'b111, 3'b000, 8'h00, 1'b0, 8'hff, 1'b1, 1'b1, 1'b1, 1'b0};
    rows[4] = '{2'b11, 32'h1357_9bdf, 32'h2468_ace0, 1'b0, 1'b1, 1'b1,
                3'b000, 3'b111, 8'h3c, 1'b1, 8'hc3, 1'b0, 1'b1, 1'b0, 1'b1};
    rows[5] = '{2'b00, 32'hfedc_ba98, 32'h7654_3210, 1'b1, 1'b1, 1'b1,
                3'b101, 3'b010, 8'h81, 1'b1, 8'h18, 1'b1, 1'b0, 1'b1, 1'b0};
    rows[6] = '{2'b00, 32'h00ff_00ff, 32'hff00_ff00, 1'b0, 1'b0, 1'b0,
                3'b011, 3'b100, 8'he7, 1'b0, 8'h7e, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[7] = '{2'b00, 32'hcafe_f00d, 32'h0bad_c0de, 1'b1, 1'b0, 1'b1,
                3'b110, 3'b001, 8'h5a, 1'b1, 8'ha5, 1'b1, 1'b1, 1'b0, 1'b1};
  endtask

  task automatic check_mux(input row_t r, input logic mode);
    check_value("bus_start_o", bus_start_o, mode ? r.i3c_ev[2] : r.i2c_ev[2]);
    check_value("bus_rstart_o", bus_rstart_o, mode ? r.i3c_ev[1] : r.i2c_ev[1]);
    check_value("bus_stop_o", bus_stop_o, mode ? r.i3c_ev[0] : r.i2c_ev[0]);
    check_value("bus_addr_o", bus_addr_o, mode ? r.i3c_addr : r.i2c_addr);
    check_value("bus_addr_valid_o", bus_addr_valid_o, mode ? r.i3c_addr_v : r.i2c_addr_v);
    check_value("tx_queue_flush_o", tx_queue_flush_o, mode & r.flush);
    check_value("ibi_rvalid_o", ibi_rvalid_o, mode & r.ibi_valid);
    check_value("ibi_queue_rready_o", ibi_queue_rready_o, mode & r.ibi_ready);
    if (mode) begin
      check_value("i2c_rx_wready_o", i2c_rx_wready_o, 1'b0);
      check_value("i2c_tx_rvalid_o", i2c_tx_rvalid_o, 1'b0);
    end else begin
      check_value("i3c_rx_wready_o", i3c_rx_wready_o, 1'b0);
      check_value("i3c_tx_rvalid_o", i3c_tx_rvalid_o, 1'b0);
    end
  endtask

  // Two RX words or four RX bytes and the TX bytes under random back-pressure
  // A second word or byte group waits while the converter is still busy
  task automatic move_data(input row_t r, input logic mode);
    int rx_sent;
    int tx_sent;
    int rx_total;
    int tx_total;
    logic [31:0] tx_src;
    rx_total = mode ? NB : 2;
    tx_total = mode ? NB : 2 * NB;
    rx_sent  = 0;
    tx_sent  = 0;
    while (1) begin
      tx_src = (tx_sent < NB) ? r.tx_bytes : ~r.tx_bytes;
      i2c_rx_wvalid_i   = !mode && (rx_sent < rx_total);
      i2c_rx_wdata_i    = (rx_sent == 0) ? r.rx_word : ~r.rx_word;
      i3c_rx_wvalid_i   = mode && (rx_sent < rx_total);
      i3c_rx_wdata_i    = r.rx_word[(rx_sent % NB)*BW +: BW];
      tx_queue_rvalid_i = (tx_sent < tx_total);
      tx_queue_rdata_i  = tx_src[(tx_sent % NB)*BW +: BW];
      rx_queue_wready_i = ($urandom % 4) != 0;
      i2c_tx_rready_i   = ($urandom % 3) != 0;
      i3c_tx_rready_i   = ($urandom % 4) != 0;
      if (rx_sent == rx_total && tx_sent == tx_total && exp_rx.size() == 0 &&
          exp_i2c_tx.size() == 0 && exp_i3c_tx.size() == 0 && tx_lane == 0) begin
        break;
      end
      @(negedge clk_i);
      if ((i2c_rx_wvalid_i && i2c_rx_wready_o) || (i3c_rx_wvalid_i && i3c_rx_wready_o)) begin
        rx_sent = rx_sent + 1;
      end
      if (tx_queue_rvalid_i && tx_queue_rready_o) begin
        tx_sent = tx_sent + 1;
      end
      @(posedge clk_i);
      #STIM_DELAY;
    end
  endtask

  task automatic run_row(input row_t r);
    logic mode;
    mode = |r.en;
    {i3c_active_en_i, i3c_standby_en_i} = r.en;
    i3c_tx_flush_i = r.flush;
    ibi_queue_rvalid_i = r.ibi_valid;
    i3c_ibi_rready_i = r.ibi_ready;
    {i2c_bus_start_i, i2c_bus_rstart_i, i2c_bus_stop_i} = r.i2c_ev;
    {i3c_bus_start_i, i3c_bus_rstart_i, i3c_bus_stop_i} = r.i3c_ev;
    i2c_bus_addr_i = r.i2c_addr;
    i2c_bus_addr_valid_i = r.i2c_addr_v;
    i3c_bus_addr_i = r.i3c_addr;
    i3c_bus_addr_valid_i = r.i3c_addr_v;
    parity_err_i = r.parity;
    get_status_done_i = r.status;
    @(negedge clk_i);
    check_mux(r, mode);
    @(posedge clk_i);
    #STIM_DELAY;
    parity_err_i = 1'b0;
    get_status_done_i = 1'b0;
    @(negedge clk_i);
    check_value("err_o", err_o, r.exp_err);
    @(posedge clk_i);
    #STIM_DELAY;
    move_data(r, mode);
  endtask

  // Watchdog
  initial begin
    #((NUM_ROWS * 200 + 10) * CLK_PERIOD);
    report_failure("Watchdog expired before all table rows completed");
  end

  initial begin
    void'($urandom(32'hbd17));
    rst_ni = 1'b0;
    {i3c_active_en_i, i3c_standby_en_i} = 2'b00;
    {i2c_rx_wvalid_i, i3c_rx_wvalid_i, rx_queue_wready_i, tx_queue_rvalid_i} = '0;
    {i2c_tx_rready_i, i3c_tx_rready_i, i3c_tx_flush_i} = '0;
    {ibi_queue_rvalid_i, i3c_ibi_rready_i} = '0;
    {i2c_bus_start_i, i2c_bus_rstart_i, i2c_bus_stop_i} = '0;
    {i3c_bus_start_i, i3c_bus_rstart_i, i3c_bus_stop_i} = '0;
    {i2c_bus_addr_i, i3c_bus_addr_i, i2c_bus_addr_valid_i, i3c_bus_addr_valid_i} = '0;
    {parity_err_i, get_status_done_i} = '0;
    i2c_rx_wdata_i = '0;
    i3c_rx_wdata_i = '0;
    tx_queue_rdata_i = '0;
    load_table();
    repeat (10) @(posedge clk_i);
    #STIM_DELAY;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("err_o", err_o, 1'b0);
    check_value("rx_queue_wvalid_o", rx_queue_wvalid_o, 1'b0);
    check_value("i2c_tx_rvalid_o", i2c_tx_rvalid_o, 1'b0);
    check_value("i2c_rx_wready_o", i2c_rx_wready_o, 1'b1);
    check_value("tx_queue_rready_o", tx_queue_rready_o, 1'b1);
    @(posedge clk_i);
    #STIM_DELAY;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog/standby_queue_bridge.sv
// Standby target queue bridge with mode select, queue and event muxes, error flag
`timescale 1ns/1ps

module standby_queue_bridge (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Mode enables
  input  logic                   i3c_active_en_i,
  input  logic                   i3c_standby_en_i,

  // I2C engine RX words
  input  logic                   i2c_rx_wvalid_i,
  input  standby_pkg::i2c_word_t i2c_rx_wdata_i,
  output logic                   i2c_rx_wready_o,

  // I3C engine RX bytes
  input  logic                   i3c_rx_wvalid_i,
  input  standby_pkg::tti_byte_t i3c_rx_wdata_i,
  output logic                   i3c_rx_wready_o,

  // RX data queue
  output logic                   rx_queue_wvalid_o,
  output standby_pkg::tti_byte_t rx_queue_wdata_o,
  input  logic                   rx_queue_wready_i,

  // TX data queue
  input  logic                   tx_queue_rvalid_i,
  input  standby_pkg::tti_byte_t tx_queue_rdata_i,
  output logic                   tx_queue_rready_o,

  // I2C engine TX words
  output logic                   i2c_tx_rvalid_o,
  output standby_pkg::i2c_word_t i2c_tx_rdata_o,
  input  logic                   i2c_tx_rready_i,

  // I3C engine TX bytes
  output logic                   i3c_tx_rvalid_o,
  output standby_pkg::tti_byte_t i3c_tx_rdata_o,
  input  logic                   i3c_tx_rready_i,

  input  logic                   i3c_tx_flush_i,
  output logic                   tx_queue_flush_o,

  // IBI queue handshake
  input  logic                   ibi_queue_rvalid_i,
  output logic                   ibi_queue_rready_o,
  output logic                   ibi_rvalid_o,
  input  logic                   i3c_ibi_rready_i,

  // Bus conditions from both engines
  input  logic                   i2c_bus_start_i,
  input  logic                   i2c_bus_rstart_i,
  input  logic                   i2c_bus_stop_i,
  input  logic                   i3c_bus_start_i,
  input  logic                   i3c_bus_rstart_i,
  input  logic                   i3c_bus_stop_i,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,

  // Received address with RnW bit
  input  logic [7:0]             i2c_bus_addr_i,
  input  logic [7:0]             i3c_bus_addr_i,
  input  logic                   i2c_bus_addr_valid_i,
  input  logic                   i3c_bus_addr_valid_i,
  output logic [7:0]             bus_addr_o,
  output logic                   bus_addr_valid_o,

  input  logic                   parity_err_i,
  input  logic                   get_status_done_i,
  output logic                   err_o
);

  // 0 selects the I2C engine, 1 the I3C engine
  logic i3c_mode;
  assign i3c_mode = i3c_active_en_i | i3c_standby_en_i;

  logic                   unpk_sink_valid;
  logic                   unpk_sink_ready;
  logic                   unpk_source_valid;
  logic                   unpk_source_ready;
  standby_pkg::tti_byte_t unpk_source_data;

  logic                   pk_sink_valid;
  logic                   pk_sink_ready;
  logic                   pk_source_valid;
  logic                   pk_source_ready;

  // Converters only see traffic in I2C mode
  assign unpk_sink_valid   = i2c_rx_wvalid_i & ~i3c_mode;
  assign unpk_source_ready = rx_queue_wready_i & ~i3c_mode;
  assign pk_sink_valid     = tx_queue_rvalid_i & ~i3c_mode;
  assign pk_source_ready   = i2c_tx_rready_i & ~i3c_mode;

  // 32 -> 8 on the RX queue
  rx_word_unpacker u_rx_unpacker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sink_valid_i   (unpk_sink_valid),
    .sink_ready_o   (unpk_sink_ready),
    .sink_data_i    (i2c_rx_wdata_i),
    .source_valid_o (unpk_source_valid),
    .source_ready_i (unpk_source_ready),
    .source_data_o  (unpk_source_data)
  );

  // 8 -> 32 on the TX queue
  tx_byte_packer u_tx_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sink_valid_i   (pk_sink_valid),
    .sink_ready_o   (pk_sink_ready),
    .sink_data_i    (tx_queue_rdata_i),
    .source_valid_o (pk_source_valid),
    .source_ready_i (pk_source_ready),
    .source_data_o  (i2c_tx_rdata_o)
  );

  always_comb begin
    // Queue side follows the active engine
    rx_queue_wvalid_o = i3c_mode ? i3c_rx_wvalid_i : unpk_source_valid;
    rx_queue_wdata_o  = i3c_mode ? i3c_rx_wdata_i : unpk_source_data;
    tx_queue_rready_o = i3c_mode ? i3c_tx_rready_i : pk_sink_ready;
    tx_queue_flush_o  = i3c_mode ? i3c_tx_flush_i : 1'b0;

    // Inactive engine handshakes held low
    i2c_rx_wready_o = ~i3c_mode & unpk_sink_ready;
    i2c_tx_rvalid_o = ~i3c_mode & pk_source_valid;
    i3c_rx_wready_o = i3c_mode & rx_queue_wready_i;
    i3c_tx_rvalid_o = i3c_mode & tx_queue_rvalid_i;
    i3c_tx_rdata_o  = tx_queue_rdata_i;

    // IBI only exists on the I3C side
    ibi_rvalid_o       = i3c_mode & ibi_queue_rvalid_i;
    ibi_queue_rready_o = i3c_mode & i3c_ibi_rready_i;

    bus_start_o      = i3c_mode ? i3c_bus_start_i : i2c_bus_start_i;
    bus_rstart_o     = i3c_mode ? i3c_bus_rstart_i : i2c_bus_rstart_i;
    bus_stop_o       = i3c_mode ? i3c_bus_stop_i : i2c_bus_stop_i;
    bus_addr_o       = i3c_mode ? i3c_bus_addr_i : i2c_bus_addr_i;
    bus_addr_valid_o = i3c_mode ? i3c_bus_addr_valid_i : i2c_bus_addr_valid_i;
  end

  // Sticky parity error
  // A finished status read clears it and wins a tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= 1'b0;
    end else if (get_status_done_i) begin
      err_o <= 1'b0;
    end else if (parity_err_i) begin
      err_o <= 1'b1;
    end
  end

endmodule

// File: width_conv/rx_word_unpacker.sv
// RX width converter that splits one 32-bit I2C word into four queue bytes
`timescale 1ns/1ps

module rx_word_unpacker (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Word side from the I2C engine
  input  logic                  sink_valid_i,
  output logic                  sink_ready_o,
  input  standby_pkg::i2c_word_t sink_data_i,

  // Byte side towards the RX data queue
  output logic                  source_valid_o,
  input  logic                  source_ready_i,
  output standby_pkg::tti_byte_t source_data_o
);

  standby_pkg::i2c_word_t  word_q;
  standby_pkg::byte_idx_t  idx_q;
  logic                    busy_q;

  logic sink_fire;
  logic source_fire;
  logic last_lane;

  // Only take a new word once every byte of the old one is gone
  assign sink_ready_o   = ~busy_q;
  assign source_valid_o = busy_q;

  assign sink_fire   = sink_valid_i & sink_ready_o;
  assign source_fire = source_valid_o & source_ready_i;
  assign last_lane   = (idx_q == standby_pkg::LAST_LANE);

  // Current lane with the least significant byte first
  assign source_data_o =
    word_q[int'(idx_q)*standby_pkg::TTI_BYTE_W +: standby_pkg::TTI_BYTE_W];

  // Word register loaded only on an accepted word
  always_ff @(posedge clk_i) begin
    if (sink_fire) begin
      word_q <= sink_data_i;
    end
  end

  // Busy flag and lane counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      if (sink_fire) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (source_fire) begin
        // Counter wraps back to lane 0 after the last byte
        idx_q <= idx_q + 1'b1;
        if (last_lane) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

// File: width_conv/tx_byte_packer.sv
// TX width converter that gathers four queue bytes into one 32-bit I2C word
`timescale 1ns/1ps

module tx_byte_packer (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Byte side from the TX data queue
  input  logic                   sink_valid_i,
  output logic                   sink_ready_o,
  input  standby_pkg::tti_byte_t sink_data_i,

  // Word side towards the I2C engine
  output logic                   source_valid_o,
  input  logic                   source_ready_i,
  output standby_pkg::i2c_word_t source_data_o
);

  standby_pkg::i2c_word_t word_q;
  standby_pkg::byte_idx_t idx_q;
  logic                   full_q;

  logic sink_fire;
  logic source_fire;
  logic last_lane;

  // Queue stalls while a complete word waits for the engine
  assign sink_ready_o   = ~full_q;
  assign source_valid_o = full_q;
  assign source_data_o  = word_q;

  assign sink_fire   = sink_valid_i & sink_ready_o;
  assign source_fire = source_valid_o & source_ready_i;
  assign last_lane   = (idx_q == standby_pkg::LAST_LANE);

  // First byte lands in the lowest lane
  always_ff @(posedge clk_i) begin
    if (sink_fire) begin
      word_q[int'(idx_q)*standby_pkg::TTI_BYTE_W +: standby_pkg::TTI_BYTE_W] <= sink_data_i;
    end
  end

  // Lane counter advances per accepted byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (sink_fire) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // Full flag set with lane 3 and dropped when the word leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else begin
      if (sink_fire && last_lane) begin
        full_q <= 1'b1;
      end else if (source_fire) begin
        full_q <= 1'b0;
      end
    end
  end

endmodule
